/* ex_unit.f */
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_multdiv.sv
logic/ex_op_stage.sv
logic/ex_block.sv
logic/ex_result_stage.sv
logic/ex_unit.sv
dv/ex_clk_gen.sv
dv/ex_unit_tb.sv

/* Makefile */
TOP := ex_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module ex_unit -f ex_unit.f
	verilator --lint-only --timing --top-module $(TOP) -f ex_unit.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f ex_unit.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* dv/ex_unit_stim.txt */
// class code operand_a operand_b expected, all fields hex
// class 0 ALU 1 MUL 2 DIV, code is the ALU op or {upper, a_signed, b_signed, spare}
0 0 7fffffff 00000001 80000000
0 1 00000000 00000001 ffffffff
0 1 80000000 00000001 7fffffff
0 2 f0f0f0f0 ff00ff00 f000f000
0 3 f0f0f0f0 0f0f0000 fffff0f0
0 4 aaaaaaaa ffffffff 55555555
0 5 00000001 00000024 00000010
0 6 80000000 0000001f 00000001
0 7 80000000 00000004 f8000000
0 7 80000010 00000021 c0000008
0 8 80000000 00000001 00000001
0 9 80000000 00000001 00000000
0 a 12345678 12345678 00000001
0 b 12345678 12345678 00000000
0 c 7fffffff 80000000 00000000
0 d ffffffff ffffffff 00000001
0 e 7fffffff 80000000 00000001
0 f 00000000 ffffffff 00000000
1 6 fffffffe 00000003 fffffffa
1 e fffffffe 00000003 ffffffff
1 c ffffffff ffffffff ffffffff
1 8 ffffffff ffffffff fffffffe
1 e 80000000 80000000 40000000
1 e 7fffffff 80000000 c0000000
2 6 fffffff9 00000002 fffffffd
2 e fffffff9 00000002 ffffffff
2 0 fffffff9 00000002 7ffffffc
2 8 fffffff9 00000002 00000001
2 6 00000007 fffffffe fffffffd
2 e 00000007 fffffffe 00000001
2 6 00000123 00000000 ffffffff
2 e 00000123 00000000 00000123
2 0 ffffffff 00000000 ffffffff
2 6 80000000 ffffffff 80000000
2 e 80000000 ffffffff 00000000

/* dv/ex_unit_tb.sv */
// Testbench top for the execute subsystem, file driven with random response back-pressure
module ex_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ex_pkg::*;

  logic    clk;
  logic    rst_n;
  logic    req_valid;
  ex_req_t req;
  logic    req_ready;
  logic    rsp_valid;
  ex_rsp_t rsp;
  logic    rsp_ready;

  // Operations and their expected results, in request order
  ex_req_t     req_arr[$];
  ex_rsp_t     exp_arr[$];
  int          n_ops;
  int          send_idx;
  int          recv_idx;
  int          extra_rsp;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] rand_state;

  ex_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_unit dut0 (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Single exit point for any failure
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_rsp(input ex_rsp_t got, input ex_rsp_t exp, input int idx);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: op %0d class %0d code %h a %h b %h got %h expected %h",
                         $time, idx, req_arr[idx].cls, req_arr[idx].op, req_arr[idx].operand_a,
                         req_arr[idx].operand_b, got.result, exp.result));
    end
  endtask

  // Comment and blank lines fail the five-field scan and drop out
  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [1:0]  cls;
    logic [3:0]  code;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    ex_req_t     r;
    ex_rsp_t     e;
    ex_req_t     alu_req[$];
    ex_rsp_t     alu_exp[$];
    ex_req_t     md_req[$];
    ex_rsp_t     md_exp[$];
    fd = $fopen("dv/ex_unit_stim.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the stimulus file dv/ex_unit_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%h %h %h %h %h", cls, code, a, b, val) == 5) begin
          r.cls       = ex_class_e'(cls);
          r.op        = code;
          r.operand_a = a;
          r.operand_b = b;
          e.result    = val;
          if (r.cls == CLS_ALU) begin
            alu_req.push_back(r);
            alu_exp.push_back(e);
          end else begin
            md_req.push_back(r);
            md_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
      // Alternate short and long operations so ALU work queues behind mult/div runs
      while (alu_req.size() > 0 || md_req.size() > 0) begin
        if (alu_req.size() > 0) begin
          req_arr.push_back(alu_req.pop_front());
          exp_arr.push_back(alu_exp.pop_front());
        end
        if (md_req.size() > 0) begin
          req_arr.push_back(md_req.pop_front());
          exp_arr.push_back(md_exp.pop_front());
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles, only %0d of %0d responses arrived",
                         cycle_cnt, recv_idx, n_ops));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    req_valid   = 1'b0;
    req         = '0;
    rsp_ready   = 1'b0;
    rand_state  = 32'hc1f5_a3ba;
    send_idx    = 0;
    recv_idx    = 0;
    extra_rsp   = 0;
    cycle_cnt   = 0;
    load_stim();
    n_ops       = req_arr.size();
    // Worst case per op is a full mult/div run plus pipeline slack
    cycle_limit = n_ops * (MD_STEPS + 8) * 4;
    if (n_ops == 0) begin
      fail_run("The stimulus file holds no operations");
    end
    wait (rst_n == 1'b1);

    // Inputs change on the falling edge, handshakes are sampled mid low phase
    while (recv_idx < n_ops) begin
      @(negedge clk);
      if (send_idx < n_ops) begin
        req_valid = 1'b1;
        req       = req_arr[send_idx];
      end else begin
        req_valid = 1'b0;
        req       = '0;
      end
      rand_state = xorshift32(rand_state);
      // Ready about three cycles in four
      rsp_ready  = (rand_state[1:0] != 2'b00);
      #2;
      if (rsp_valid && rsp_ready) begin
        if (recv_idx >= send_idx) begin
          fail_run("A response came out with no request outstanding");
        end
        compare_rsp(rsp, exp_arr[recv_idx], recv_idx);
        recv_idx++;
      end
      if (req_valid && req_ready) begin
        send_idx++;
      end
    end

    // Nothing more may come out once all results are in
    repeat (8) begin
      @(negedge clk);
      req_valid = 1'b0;
      req       = '0;
      rsp_ready = 1'b1;
      #2;
      if (rsp_valid) begin
        extra_rsp++;
      end
    end

    if (extra_rsp == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_run($sformatf("%0d responses came out after the last expected one", extra_rsp));
    end
  end

endmodule

/* dv/ex_clk_gen.sv */
// Testbench clock and reset generator, 8 ns clock with reset held for 8 cycles
module ex_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Half of the 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the flops
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* logic/ex_unit.sv */
// Execute subsystem top chaining operation, execute and result stages
module ex_unit (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            req_valid_i,
  input  ex_pkg::ex_req_t req_i,
  output logic            req_ready_o,
  output logic            rsp_valid_o,
  output ex_pkg::ex_rsp_t rsp_o,
  input  logic            rsp_ready_i
);
  import ex_pkg::*;

  // Operation stage to execute stage
  logic    cmd_valid;
  logic    cmd_ready;
  ex_cmd_t cmd;

  // Execute stage to result stage
  logic    res_valid;
  logic    res_ready;
  ex_rsp_t res;

  ex_op_stage op_stage_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .cmd_ready_i (cmd_ready)
  );

  ex_block ex_block_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_ready_o (cmd_ready),
    .res_valid_o (res_valid),
    .res_o       (res),
    .res_ready_i (res_ready)
  );

  ex_result_stage result_stage_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .res_valid_i (res_valid),
    .res_i       (res),
    .res_ready_o (res_ready),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

/* logic/ex_result_stage.sv */
// Result register slice holding one word under back-pressure
module ex_result_stage (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            res_valid_i,
  input  ex_pkg::ex_rsp_t res_i,
  output logic            res_ready_o,
  output logic            rsp_valid_o,
  output ex_pkg::ex_rsp_t rsp_o,
  input  logic            rsp_ready_i
);
  import ex_pkg::*;

  logic    valid_q;
  ex_rsp_t data_q;

  // Accept when empty or draining, keeps full throughput
  assign res_ready_o = !valid_q || rsp_ready_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (res_ready_o) begin
      valid_q <= res_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid_i && res_ready_o) begin
      data_q <= res_i;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_o       = data_q;

endmodule

/* logic/ex_block.sv */
// Execute stage hosting the ALU and mult/div unit with result select and stall control
module ex_block (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            cmd_valid_i,
  input  ex_pkg::ex_cmd_t cmd_i,
  output logic            cmd_ready_o,
  output logic            res_valid_o,
  output ex_pkg::ex_rsp_t res_o,
  input  logic            res_ready_i
);
  import ex_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] md_result;
  logic            md_path;
  logic            md_start;
  logic            md_done;
  logic            md_run_q;
  logic            unit_ready;

  ex_alu alu_i (
    .op_i        (cmd_i.op.alu),
    .operand_a_i (cmd_i.operand_a),
    .operand_b_i (cmd_i.operand_b),
    .result_o    (alu_result)
  );

  ex_multdiv multdiv_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .start_i  (md_start),
    .cmd_i    (cmd_i),
    .result_o (md_result),
    .done_o   (md_done),
    .ack_i    (cmd_ready_o)
  );

  // Special cases skip the iteration
  assign md_path  = (cmd_i.cls != CLS_ALU) && !cmd_i.special;
  // Kick off once per command
  assign md_start = cmd_valid_i && md_path && !md_run_q;

  // Stall control
  always_comb begin
    unique case (1'b1)
      md_path: unit_ready = md_done;
      // Single cycle case
      default: unit_ready = 1'b1;
    endcase
  end

  assign res_valid_o = cmd_valid_i && unit_ready;
  // Command retires only together with its result
  assign cmd_ready_o = res_valid_o && res_ready_i;

  always_comb begin
    if (cmd_i.special) begin
      res_o.result = cmd_i.special_value;
    end else if (cmd_i.cls == CLS_ALU) begin
      res_o.result = alu_result;
    end else begin
      res_o.result = md_result;
    end
  end

  // Running flag, held until the result is taken
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      md_run_q <= 1'b0;
    end else if (md_start) begin
      md_run_q <= 1'b1;
    end else if (md_done && cmd_ready_o) begin
      md_run_q <= 1'b0;
    end
  end

endmodule

/* logic/ex_op_stage.sv */
// Operation stage registering requests and resolving mult/div signs and special cases
module ex_op_stage (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            req_valid_i,
  input  ex_pkg::ex_req_t req_i,
  output logic            req_ready_o,
  output logic            cmd_valid_o,
  output ex_pkg::ex_cmd_t cmd_o,
  input  logic            cmd_ready_i
);
  import ex_pkg::*;

  ex_cmd_t cmd_d;
  ex_cmd_t cmd_q;
  logic    valid_q;
  logic    is_md;
  logic    a_neg;
  logic    b_neg;
  logic    div_zero;
  logic    div_ovf;

  // Sign of each operand only counts when that operand is signed
  assign is_md = req_i.cls != CLS_ALU;
  assign a_neg = is_md && req_i.op.md.a_signed && req_i.operand_a[XLEN-1];
  assign b_neg = is_md && req_i.op.md.b_signed && req_i.operand_b[XLEN-1];

  // RV32M corner cases
  assign div_zero = (req_i.cls == CLS_DIV) && (req_i.operand_b == '0);
  assign div_ovf  = (req_i.cls == CLS_DIV) && req_i.op.md.a_signed && req_i.op.md.b_signed &&
                    (req_i.operand_a == {1'b1, {(XLEN-1){1'b0}}}) && (req_i.operand_b == '1);

  always_comb begin
    cmd_d.cls           = req_i.cls;
    cmd_d.op            = req_i.op;
    cmd_d.operand_a     = req_i.operand_a;
    cmd_d.operand_b     = req_i.operand_b;
    // Absolute values feed the unsigned iterative unit
    cmd_d.mag_a         = a_neg ? -req_i.operand_a : req_i.operand_a;
    cmd_d.mag_b         = b_neg ? -req_i.operand_b : req_i.operand_b;
    cmd_d.neg_result    = 1'b0;
    cmd_d.special       = 1'b0;
    cmd_d.special_value = '0;
    case (req_i.cls)
      CLS_MUL: begin
        // Product is negative when exactly one factor is
        cmd_d.neg_result = a_neg ^ b_neg;
      end
      CLS_DIV: begin
        // Remainder follows the dividend, quotient the sign mix
        cmd_d.neg_result = req_i.op.md.upper ? a_neg : (a_neg ^ b_neg);
        if (div_zero) begin
          cmd_d.special       = 1'b1;
          cmd_d.special_value = req_i.op.md.upper ? req_i.operand_a : '1;
        end else if (div_ovf) begin
          cmd_d.special       = 1'b1;
          cmd_d.special_value = req_i.op.md.upper ? '0 : req_i.operand_a;
        end
      end
      default: ;
    endcase
  end

  // Empty, or emptied this cycle
  assign req_ready_o = !valid_q || cmd_ready_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      cmd_q <= cmd_d;
    end
  end

  assign cmd_valid_o = valid_q;
  assign cmd_o       = cmd_q;

endmodule

/* logic/ex_multdiv.sv */
// Iterative shift-add multiplier and restoring divider on unsigned magnitudes
module ex_multdiv (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  ex_pkg::ex_cmd_t         cmd_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    done_o,
  input  logic                    ack_i
);
  import ex_pkg::*;

  logic [MD_CNT_W-1:0] cnt_q;
  logic                done_q;
  logic                is_mul;
  logic [2*XLEN-1:0]   acc_q;
  logic [XLEN:0]       acc_sum;
  logic [XLEN-1:0]     rem_q;
  logic [XLEN-1:0]     quo_q;
  logic [XLEN:0]       rem_shift;
  logic [XLEN+1:0]     rem_diff;
  logic [2*XLEN-1:0]   prod;
  logic [XLEN-1:0]     div_sel;

  // cmd_i stays stable until its result is taken
  assign is_mul = (cmd_i.cls == CLS_MUL);

  // Multiply step, add multiplicand when the low bit is set
  assign acc_sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + {1'b0, cmd_i.mag_a & {XLEN{acc_q[0]}}};

  // Divide step, bring in the next dividend bit and try the subtract
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign rem_diff  = {1'b0, rem_shift} - {2'b00, cmd_i.mag_b};

  ////////////////////////////////////////////////////////////////////////////
  // Step control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (start_i) begin
      cnt_q  <= MD_CNT_W'(MD_STEPS);
      done_q <= 1'b0;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
      // Last step sets done
      if (cnt_q == MD_CNT_W'(1)) begin
        done_q <= 1'b1;
      end
    end else if (ack_i) begin
      done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      // Multiplier sits in the low half and shifts out
      acc_q <= {{XLEN{1'b0}}, cmd_i.mag_b};
      rem_q <= '0;
      quo_q <= cmd_i.mag_a;
    end else if (cnt_q != '0) begin
      if (is_mul) begin
        acc_q <= {acc_sum, acc_q[XLEN-1:1]};
      end else if (rem_diff[XLEN+1]) begin
        // Trial went negative, restore
        rem_q <= rem_shift[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end else begin
        rem_q <= rem_diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result select and sign fix
  ////////////////////////////////////////////////////////////////////////////

  // Negate the full product so the high word is right too
  assign prod    = cmd_i.neg_result ? -acc_q : acc_q;
  assign div_sel = cmd_i.op.md.upper ? rem_q : quo_q;

  always_comb begin
    if (is_mul) begin
      result_o = cmd_i.op.md.upper ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
    end else begin
      result_o = cmd_i.neg_result ? -div_sel : div_sel;
    end
  end

  assign done_o = done_q;

endmodule

/* logic/ex_alu.sv */
// Single-cycle ALU with shared adder, logic ops, shifter and comparator
module ex_alu (
  input  ex_pkg::alu_op_e           op_i,
  input  logic [ex_pkg::XLEN-1:0]   operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]   operand_b_i,
  output logic [ex_pkg::XLEN-1:0]   result_o
);
  import ex_pkg::*;

  logic                     sub;
  logic [XLEN-1:0]          b_eff;
  logic [XLEN:0]            sum;
  logic                     is_eq;
  logic                     lt_s;
  logic                     lt_u;
  logic                     cmp;
  logic [$clog2(XLEN)-1:0]  shamt;

  ////////////////////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////////////////////

  // Everything except ADD wants a - b
  assign sub   = (op_i != ALU_ADD);
  assign b_eff = operand_b_i ^ {XLEN{sub}};
  // Carry-in completes the two's complement
  assign sum   = {1'b0, operand_a_i} + {1'b0, b_eff} + {{XLEN{1'b0}}, sub};

  // Compare flags from the subtraction
  assign is_eq = (operand_a_i == operand_b_i);
  // No borrow means a >= b unsigned
  assign lt_u  = !sum[XLEN];
  // Same signs cannot overflow, so the difference sign is enough
  assign lt_s  = (operand_a_i[XLEN-1] == operand_b_i[XLEN-1]) ? sum[XLEN-1]
                                                               : operand_a_i[XLEN-1];

  always_comb begin
    case (op_i)
      ALU_EQ:            cmp = is_eq;
      ALU_NE:            cmp = !is_eq;
      ALU_SLT, ALU_LT:   cmp = lt_s;
      ALU_GE:            cmp = !lt_s;
      ALU_SLTU, ALU_LTU: cmp = lt_u;
      ALU_GEU:           cmp = !lt_u;
      default:           cmp = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  // Only the low five bits of b shift
  assign shamt = operand_b_i[$clog2(XLEN)-1:0];

  always_comb begin
    case (op_i)
      ALU_ADD, ALU_SUB: result_o = sum[XLEN-1:0];
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = operand_a_i << shamt;
      ALU_SRL:          result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:          result_o = $unsigned($signed(operand_a_i) >>> shamt);
      default:          result_o = {{(XLEN-1){1'b0}}, cmp};
    endcase
  end

endmodule

/* logic/ex_pkg.sv */
// Execute subsystem package with widths, operation encodings and stage packets
package ex_pkg;

  // Datapath width and iterative unit length
  localparam int XLEN     = 32;
  localparam int MD_STEPS = 32;
  // Counter must hold MD_STEPS itself
  localparam int MD_CNT_W = $clog2(MD_STEPS + 1);

  // Operation class picks the unit
  typedef enum logic [1:0] {
    CLS_ALU = 2'd0,
    CLS_MUL = 2'd1,
    CLS_DIV = 2'd2
  } ex_class_e;

  // ALU operations, compares return 1 or 0
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiply/divide flags
  // upper: high word for multiply, remainder for divide
  typedef struct packed {
    logic upper;
    logic a_signed;
    logic b_signed;
    logic spare;
  } md_op_t;

  // Same four bits, meaning depends on class
  typedef union packed {
    alu_op_e alu;
    md_op_t  md;
  } ex_op_u;

  // Incoming request, 70 bits
  typedef struct packed {
    ex_class_e       cls;
    ex_op_u          op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } ex_req_t;

  // Prepared command for the execute stage
  typedef struct packed {
    ex_class_e       cls;
    ex_op_u          op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;
    logic            neg_result;
    logic            special;
    logic [XLEN-1:0] special_value;
  } ex_cmd_t;

  // Result word
  typedef struct packed {
    logic [XLEN-1:0] result;
  } ex_rsp_t;

endpackage
